// File: all.f
hw/cache_store_pkg.sv
hw/cache_bus_pkg.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// File: Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= run.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS      := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS  ?= hw/cache_store_pkg.sv hw/cache_bus_pkg.sv hw/dcache_lookup.sv \
             hw/dcache_ctrl.sv hw/dcache_top.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/dcache_tb.sv
// testbench of the data cache: word accesses checked against a reference cache model
`timescale 1ns/10ps

module dcache_tb
	import cache_store_pkg::*;
	import cache_bus_pkg::*;
();

	localparam int SETS_LOG2       = 2;
	localparam int SETS            = 1 << SETS_LOG2;
	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 10;
	localparam int MEM_LATENCY     = 3;
	localparam int RANDOM_ACCESSES = 300;
	// directed tests issue 14 accesses
	localparam int TOTAL_ACCESSES  = 14 + RANDOM_ACCESSES;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_ACCESSES * (2 * MEM_LATENCY + 4) + 200;

	// one expected memory transaction
	typedef struct packed {
		logic       write;
		line_addr_t addr;
		line_data_u data;
	} txn_t;

	// one expected processor access
	typedef struct packed {
		logic  write;
		word_t word;
	} access_t;

	logic      clk;
	logic      proc_reset;
	proc_req_t proc_req;
	proc_rsp_t proc_rsp;
	mem_req_t  mem_req;
	mem_rsp_t  mem_rsp;

	// shadow cache and memory
	way_entry_t shadow_way [2][SETS];
	logic [SETS-1:0] shadow_lru;
	line_data_u shadow_mem [line_addr_t];
	txn_t    exp_txn [$];
	access_t exp_access [$];

	int errors;
	int checks;
	int accesses;
	int errors_at_start;

	dcache_top #(.SETS_LOG2(SETS_LOG2)) i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rsp   (proc_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	dcache_mem_model #(.LATENCY(MEM_LATENCY)) u_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_line(input string name, input line_data_u got, input line_data_u exp);
		checks++;
		if (got.flat !== exp.flat) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got.flat, exp.flat, $time);
		end
	endtask

	task automatic check_line_addr(input string name, input line_addr_t got, input line_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// same power-up pattern as the memory model
	function automatic line_data_u mem_line(input line_addr_t addr);
		line_data_u line;
		if (shadow_mem.exists(addr)) begin
			return shadow_mem[addr];
		end
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			line.words[i] = {addr, 4'(i)} ^ 32'h5a00_0000;
		end
		return line;
	endfunction

	// queues the memory traffic of one access, returns the word it should read
	function automatic word_t ref_access(input proc_req_t req, output logic was_hit);
		line_addr_t line;
		txn_t       t;
		int         set;
		int         ofs;
		int         way;
		line = req.addr[WORD_ADDR_BITS-1:WORD_OFS_BITS];
		set  = int'(line[SETS_LOG2-1:0]);
		ofs  = int'(req.addr[WORD_OFS_BITS-1:0]);
		way  = -1;
		for (int w = 0; w < 2; w++) begin
			if (shadow_way[w][set].valid && shadow_way[w][set].tag == line)
				way = w;
		end
		was_hit = (way >= 0);
		if (!was_hit) begin
			// empty way first, then the LRU way
			if (!shadow_way[0][set].valid)
				way = 0;
			else if (!shadow_way[1][set].valid)
				way = 1;
			else
				way = int'(shadow_lru[set]);
			if (shadow_way[way][set].valid && shadow_way[way][set].dirty) begin
				t = '{write: 1'b1, addr: shadow_way[way][set].tag, data: shadow_way[way][set].data};
				exp_txn.push_back(t);
				shadow_mem[t.addr] = t.data;
			end
			t = '{write: 1'b0, addr: line, data: mem_line(line)};
			exp_txn.push_back(t);
			shadow_way[way][set] = '{valid: 1'b1, dirty: 1'b0, tag: line, data: t.data};
		end
		// other way becomes LRU
		shadow_lru[set] = (way == 0);
		if (req.write) begin
			shadow_way[way][set].data.words[ofs] = req.wdata;
			shadow_way[way][set].dirty           = 1'b1;
		end
		return shadow_way[way][set].data.words[ofs];
	endfunction

	// ------------------------------------------------------------
	// compare process, sampled mid-cycle
	// ------------------------------------------------------------

	always @(negedge clk) begin
		txn_t    t;
		access_t a;
		if (!proc_reset && mem_rsp.ready) begin
			if (exp_txn.size() == 0) begin
				errors++;
				$display("unexpected memory transaction (write %0b) for line 0x%h at %0t",
					mem_req.write, mem_req.addr, $time);
			end else begin
				t = exp_txn.pop_front();
				checks++;
				if (mem_req.write !== t.write) begin
					errors++;
					$display("** Error: mem_req.write = 0x%h, expected 0x%h at %0t",
						mem_req.write, t.write, $time);
				end
				checks++;
				if (mem_req.read !== !t.write) begin
					errors++;
					$display("** Error: mem_req.read = 0x%h, expected 0x%h at %0t",
						mem_req.read, !t.write, $time);
				end
				check_line_addr("mem_req.addr", mem_req.addr, t.addr);
				if (t.write)
					check_line("mem_req.wdata", mem_req.wdata, t.data);
				else
					check_line("mem_rsp.rdata", mem_rsp.rdata, t.data);
			end
		end
		// access completes in its first cycle without stall
		if (!proc_reset && (proc_req.read || proc_req.write) && !proc_rsp.stall) begin
			if (exp_access.size() == 0) begin
				errors++;
				$display("access completed with none outstanding at %0t", $time);
			end else begin
				a = exp_access.pop_front();
				if (!a.write)
					check_word("proc_rsp.rdata", proc_rsp.rdata, a.word);
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic run_access(input logic wr, input line_addr_t line,
		input logic [WORD_OFS_BITS-1:0] ofs, input word_t wdata);
		proc_req_t req;
		access_t   a;
		logic      exp_hit;
		int        stalls;
		logic      done;
		req.read  = !wr;
		req.write = wr;
		req.addr  = {line, ofs};
		req.wdata = wr ? wdata : '0;
		a.write   = wr;
		a.word    = ref_access(req, exp_hit);
		exp_access.push_back(a);
		proc_req  = req;
		stalls    = 0;
		done      = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (proc_rsp.stall)
				stalls++;
			else
				done = 1'b1;
		end
		if (exp_hit && stalls != 0) begin
			errors++;
			$display("hit on line 0x%h stalled for %0d cycles", line, stalls);
		end else if (!exp_hit && stalls == 0) begin
			errors++;
			$display("miss on line 0x%h completed without a stall", line);
		end
		accesses++;
		next_cycle();
		proc_req = '0;
	endtask

	task automatic end_test(input string name);
		if (exp_txn.size() != 0) begin
			errors++;
			$display("%0d expected memory transactions never happened", exp_txn.size());
			exp_txn.delete();
		end
		$display("test %-28s done, %0d errors", name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	initial begin
		line_addr_t line;
		word_t      wdata;
		proc_reset = 1'b1;
		proc_req   = '0;
		void'($urandom(32'h1cc2_4f5c));
		shadow_lru = '0;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < SETS; s++)
				shadow_way[w][s] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		proc_reset = 1'b0;

		// quiet after reset, then a cold miss
		@(negedge clk);
		checks++;
		if (proc_rsp.stall || mem_req.read || mem_req.write) begin
			errors++;
			$display("stall or memory request high after reset");
		end
		next_cycle();
		run_access(1'b0, 28'h100, 2'd0, '0);
		end_test("reset and cold miss");

		run_access(1'b0, 28'h205, 2'd1, '0);
		run_access(1'b0, 28'h205, 2'd3, '0);
		end_test("read miss then hit");

		wdata = $urandom;
		run_access(1'b1, 28'h205, 2'd2, wdata);
		run_access(1'b0, 28'h205, 2'd2, '0);
		end_test("write hit then read");

		// set 2, both ways dirty, then a third line
		run_access(1'b1, 28'h302, 2'd0, 32'hdead_0302);
		run_access(1'b1, 28'h406, 2'd1, 32'hbeef_0406);
		run_access(1'b0, 28'h50a, 2'd3, '0);
		end_test("dirty victim write-back");

		// set 3, A B A C evicts B
		run_access(1'b0, 28'h013, 2'd0, '0);
		run_access(1'b0, 28'h027, 2'd0, '0);
		run_access(1'b0, 28'h013, 2'd1, '0);
		run_access(1'b0, 28'h03b, 2'd2, '0);
		run_access(1'b0, 28'h013, 2'd2, '0);
		run_access(1'b0, 28'h027, 2'd3, '0);
		end_test("LRU replacement");

		// 16 lines over all four sets
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			line  = line_addr_t'($urandom_range(15, 0));
			wdata = $urandom;
			run_access(1'($urandom_range(1, 0)), line, 2'($urandom_range(3, 0)), wdata);
		end
		end_test("random mix");

		$display("%0d accesses, %0d checks, %0d errors", accesses, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// run length bound from the worst-case miss time
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, cache stopped answering", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: verification/dcache_mem_model.sv
// slow line-wide memory for the cache testbench, answers each request after a fixed latency
`timescale 1ns/10ps

module dcache_mem_model
	import cache_store_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int LATENCY = 3
) (
	input  logic     clk,
	input  logic     proc_reset,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	// only lines written back are stored
	line_data_u store [line_addr_t];
	int         wait_cnt;

	// power-up contents, every word carries its full line address and offset
	function automatic line_data_u initial_line(input line_addr_t addr);
		line_data_u line;
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			line.words[i] = {addr, 4'(i)} ^ 32'h5a00_0000;
		end
		return line;
	endfunction

	function automatic line_data_u read_line(input line_addr_t addr);
		if (store.exists(addr)) begin
			return store[addr];
		end
		return initial_line(addr);
	endfunction

	// ------------------------------------------------------------
	// request handling
	// ------------------------------------------------------------

	always @(posedge clk) begin
		if (proc_reset) begin
			wait_cnt <= 0;
			mem_rsp  <= '0;
		end else begin
			mem_rsp.ready <= 1'b0;
			// ready cycle ends the transaction, the next request starts fresh
			if ((mem_req.read || mem_req.write) && !mem_rsp.ready) begin
				if (wait_cnt == LATENCY - 1) begin
					wait_cnt      <= 0;
					mem_rsp.ready <= 1'b1;
					if (mem_req.write) begin
						store[mem_req.addr] = mem_req.wdata;
					end else begin
						mem_rsp.rdata <= read_line(mem_req.addr);
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule

// File: hw/dcache_top.sv
// top level of the two-way write-back data cache, joins controller and lookup storage
`timescale 1ns/10ps

module dcache_top
	import cache_store_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int SETS_LOG2 = 2
) (
	input  logic      clk,
	input  logic      proc_reset,
	input  proc_req_t proc_req,
	output proc_rsp_t proc_rsp,
	output mem_req_t  mem_req,
	input  mem_rsp_t  mem_rsp
);

	// lookup to controller
	logic       hit;
	logic       victim_dirty;
	way_entry_t victim;
	// controller to lookup
	logic       fill_en;
	logic       clean_en;
	// processor response parts
	logic       stall;
	word_t      rdata;

	assign proc_rsp = '{stall: stall, rdata: rdata};

	dcache_ctrl u_ctrl (
		.clk           (clk),
		.proc_reset    (proc_reset),
		.proc_req      (proc_req),
		.hit           (hit),
		.victim_dirty  (victim_dirty),
		.victim        (victim),
		.mem_rsp_ready (mem_rsp.ready),
		.mem_req       (mem_req),
		.stall         (stall),
		.fill_en       (fill_en),
		.clean_en      (clean_en)
	);

	dcache_lookup #(
		.SETS_LOG2 (SETS_LOG2)
	) u_lookup (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_req     (proc_req),
		.mem_rdata    (mem_rsp.rdata),
		.fill_en      (fill_en),
		.clean_en     (clean_en),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim       (victim),
		.rdata        (rdata)
	);

endmodule

// File: hw/dcache_ctrl.sv
// miss-handling FSM of the data cache: compare, write-back and allocate with memory and stall
`timescale 1ns/10ps

module dcache_ctrl
	import cache_store_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic       clk,
	input  logic       proc_reset,
	input  proc_req_t  proc_req,
	input  logic       hit,
	input  logic       victim_dirty,
	input  way_entry_t victim,
	input  logic       mem_rsp_ready,
	output mem_req_t   mem_req,
	output logic       stall,
	output logic       fill_en,
	output logic       clean_en
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic        miss;

	// hit already includes the request, so no request means no miss
	assign miss = (proc_req.read | proc_req.write) & ~hit;

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------
	// next state
	// ------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				state_d = st_compare;
			end
			st_compare: begin
				// dirty victim goes out before the new line comes in
				if (miss) begin
					state_d = victim_dirty ? st_write_back : st_allocate;
				end
			end
			st_write_back: begin
				if (mem_rsp_ready) begin
					state_d = st_allocate;
				end
			end
			st_allocate: begin
				// back to compare, the retry then hits
				if (mem_rsp_ready) begin
					state_d = st_compare;
				end
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	// ------------------------------------------------------------
	// memory request, stall and storage strobes
	// ------------------------------------------------------------

	always_comb begin
		mem_req = '0;
		case (state_q)
			st_write_back: begin
				// victim tag is the full line address
				mem_req.write = 1'b1;
				mem_req.addr  = victim.tag;
				mem_req.wdata = victim.data;
			end
			st_allocate: begin
				mem_req.read = 1'b1;
				mem_req.addr = proc_req.addr[WORD_ADDR_BITS-1:WORD_OFS_BITS];
			end
			default: begin
				mem_req = '0;
			end
		endcase
	end

	// idle only follows reset, all ways invalid, so it stalls like compare
	assign stall    = (state_q == st_write_back) || (state_q == st_allocate) || miss;
	// one-cycle strobes on the ready pulse
	assign clean_en = (state_q == st_write_back) && mem_rsp_ready;
	assign fill_en  = (state_q == st_allocate) && mem_rsp_ready;

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
		else $error("memory read and write together");

	// back-pressure keeps the memory request steady
	a_req_hold: assert property (@(posedge clk) disable iff (proc_reset)
		((mem_req.read || mem_req.write) && !mem_rsp_ready) |=> $stable(mem_req))
		else $error("memory request changed before ready");

endmodule

// File: hw/dcache_lookup.sv
// two-way tag/data/LRU storage of the data cache: hit detection, word access, fill and victim
`timescale 1ns/10ps

module dcache_lookup
	import cache_store_pkg::*;
	import cache_bus_pkg::*;
#(
	parameter int SETS_LOG2 = 2
) (
	input  logic       clk,
	input  logic       proc_reset,
	input  proc_req_t  proc_req,
	input  line_data_u mem_rdata,
	input  logic       fill_en,
	input  logic       clean_en,
	output logic       hit,
	output logic       victim_dirty,
	output way_entry_t victim,
	output word_t      rdata
);

	localparam int SETS = 1 << SETS_LOG2;

	// way_mem[0] and way_mem[1] are the two ways
	way_entry_t way_mem [2][SETS];
	// names the least recently used way of each set
	logic [SETS-1:0] lru_q;

	line_addr_t               line_addr;
	logic [SETS_LOG2-1:0]     set_idx;
	logic [WORD_OFS_BITS-1:0] word_sel;
	logic                     req;
	way_entry_t               entry [2];
	logic [1:0]               way_hit;
	logic                     hit_way;
	logic                     victim_way;

	// ------------------------------------------------------------
	// address split
	// ------------------------------------------------------------

	assign req       = proc_req.read | proc_req.write;
	assign line_addr = proc_req.addr[WORD_ADDR_BITS-1:WORD_OFS_BITS];
	// set field is the low end of the line address
	assign set_idx   = line_addr[SETS_LOG2-1:0];
	assign word_sel  = proc_req.addr[WORD_OFS_BITS-1:0];

	// ------------------------------------------------------------
	// tag compare, both ways in parallel
	// ------------------------------------------------------------

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			entry[w]   = way_mem[w][set_idx];
			way_hit[w] = entry[w].valid && (entry[w].tag == line_addr);
		end
	end

	// at most one way hits, so way 1 alone picks the way
	assign hit_way = way_hit[1];
	assign hit     = req & (|way_hit);

	// word read through the word view
	// only meaningful when hit is high
	assign rdata = entry[hit_way].data.words[word_sel];

	// ------------------------------------------------------------
	// victim choice
	// ------------------------------------------------------------

	// empty way first, way 0 before way 1, then the LRU way
	always_comb begin
		if (!entry[0].valid) begin
			victim_way = 1'b0;
		end else if (!entry[1].valid) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[set_idx];
		end
	end

	assign victim       = entry[victim_way];
	// stays put across write-back and allocate, the choice ignores dirty
	assign victim_dirty = victim.valid & victim.dirty;

	// ------------------------------------------------------------
	// storage update
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			// every entry invalid, tags and data left as they are
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < SETS; s++) begin
					way_mem[w][s].valid <= 1'b0;
					way_mem[w][s].dirty <= 1'b0;
				end
			end
			lru_q <= '0;
		end else begin
			// any hit makes the other way the LRU one
			if (hit) begin
				lru_q[set_idx] <= ~hit_way;
			end
			// write hit merges one word and marks the line dirty
			if (hit && proc_req.write) begin
				way_mem[hit_way][set_idx].data.words[word_sel] <= proc_req.wdata;
				way_mem[hit_way][set_idx].dirty                <= 1'b1;
			end
			// write-back accepted by memory
			if (clean_en) begin
				way_mem[victim_way][set_idx].dirty <= 1'b0;
			end
			// new line from memory into the victim way
			if (fill_en) begin
				way_mem[victim_way][set_idx] <= '{
					valid: 1'b1,
					dirty: 1'b0,
					tag:   line_addr,
					data:  mem_rdata
				};
				lru_q[set_idx] <= ~victim_way;
			end
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------

	// a line lives in one way only
	a_one_way_hits: assert property (@(posedge clk) disable iff (proc_reset)
		!(way_hit[0] && way_hit[1]))
		else $error("both ways hit in set %0d", set_idx);

	// controller only fills on a real miss
	a_fill_on_miss: assert property (@(posedge clk) disable iff (proc_reset)
		fill_en |-> (way_hit == 2'b00))
		else $error("fill while line already present");

endmodule

// File: hw/cache_bus_pkg.sv
// request and response structs for the processor-side and memory-side cache ports
package cache_bus_pkg;

	import cache_store_pkg::*;

	// ------------------------------------------------------------
	// processor side, one word per access
	// ------------------------------------------------------------

	// read and write are never high together
	// held steady while stall is high
	typedef struct packed {
		logic                      read;
		logic                      write;
		logic [WORD_ADDR_BITS-1:0] addr;
		word_t                     wdata;
	} proc_req_t;

	// access completes in the first cycle with stall low
	typedef struct packed {
		logic  stall;
		word_t rdata;
	} proc_rsp_t;

	// ------------------------------------------------------------
	// memory side, one line per transaction
	// ------------------------------------------------------------

	// held until ready, dropped the cycle after
	typedef struct packed {
		logic       read;
		logic       write;
		line_addr_t addr;
		line_data_u wdata;
	} mem_req_t;

	// ready pulses for one cycle
	// rdata only valid with ready
	typedef struct packed {
		logic       ready;
		line_data_u rdata;
	} mem_rsp_t;

endpackage

// File: hw/cache_store_pkg.sv
// storage types and line geometry shared by the cache lookup block and its controller
package cache_store_pkg;

	// ------------------------------------------------------------
	// line geometry
	// ------------------------------------------------------------

	// one processor word
	localparam int WORD_BITS      = 32;
	// words per cache line, so 128-bit lines
	localparam int WORDS_PER_LINE = 4;
	localparam int WORD_OFS_BITS  = $clog2(WORDS_PER_LINE);
	localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
	// word address minus the word offset
	localparam int LINE_ADDR_BITS = 28;
	localparam int WORD_ADDR_BITS = LINE_ADDR_BITS + WORD_OFS_BITS;

	// ------------------------------------------------------------
	// storage types
	// ------------------------------------------------------------

	typedef logic [WORD_BITS-1:0]      word_t;
	typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

	// flat view goes to the memory bus
	// word view is indexed by the word offset
	typedef union packed {
		logic [LINE_BITS-1:0]           flat;
		word_t [WORDS_PER_LINE-1:0]     words;
	} line_data_u;

	// one way of one set
	// tag holds the whole line address, set bits included
	typedef struct packed {
		logic       valid;
		logic       dirty;
		line_addr_t tag;
		line_data_u data;
	} way_entry_t;

	// controller states of the miss FSM
	typedef enum logic [1:0] {
		st_compare    = 2'b00,
		st_write_back = 2'b01,
		st_allocate   = 2'b10,
		st_idle       = 2'b11
	} ctrl_state_t;

endpackage
